/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - hdl

sources:
  # Synthesizable core, package first
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/rv_decode_stage.sv
      - hdl/rv_alu.sv
      - hdl/rv_branch_unit.sv
      - hdl/rv_retire.sv
      - hdl/rv_core.sv

  # Bound assertions and testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/rv_core_sva.sv
      - tb/tb_rv_core.sv

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*; (
    input  opcode_e x_op,
    input  alu_op_e x_alu_op,
    input  word_t   x_pc,
    input  word_t   x_rs1_val,
    input  word_t   x_rs2_val,
    input  word_t   x_imm,
    output word_t   alu_result
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      calc;

    // Operand selection
    assign op_a  = (x_op == OPC_AUIPC) ? x_pc : x_rs1_val;
    assign op_b  = (x_op == OPC_OP) ? x_rs2_val : x_imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (x_alu_op)
            ALU_ADD:    calc = op_a + op_b;
            ALU_SUB:    calc = op_a - op_b;
            ALU_SLL:    calc = op_a << shamt;
            ALU_SLT:    calc = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   calc = word_t'(op_a < op_b);
            ALU_XOR:    calc = op_a ^ op_b;
            ALU_SRL:    calc = op_a >> shamt;
            ALU_SRA:    calc = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     calc = op_a | op_b;
            ALU_AND:    calc = op_a & op_b;
            // LUI passes the U immediate through
            ALU_PASS_B: calc = op_b;
            default:    calc = op_a + op_b;
        endcase
    end

    // JAL links to the next sequential instruction
    assign alu_result = (x_op == OPC_JAL) ? x_pc + 32'd4 : calc;

endmodule

/* hdl/rv_branch_unit.sv */
`timescale 1ns/1ps

module rv_branch_unit import rv_core_pkg::*; (
    input  logic       x_valid,
    input  opcode_e    x_op,
    input  logic [2:0] x_funct3,
    input  word_t      x_pc,
    input  word_t      x_rs1_val,
    input  word_t      x_rs2_val,
    input  word_t      x_imm,
    output logic       branch_taken,
    output word_t      branch_target
);

    logic eq;
    logic lt;
    logic ltu;
    logic cond;

    // Comparator
    assign eq  = (x_rs1_val == x_rs2_val);
    assign lt  = ($signed(x_rs1_val) < $signed(x_rs2_val));
    assign ltu = (x_rs1_val < x_rs2_val);

    always_comb begin
        case (x_funct3)
            3'b000:  cond = eq;
            3'b001:  cond = !eq;
            3'b100:  cond = lt;
            3'b101:  cond = !lt;
            3'b110:  cond = ltu;
            3'b111:  cond = !ltu;
            // Reserved encodings never branch
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken  = x_valid && (((x_op == OPC_BRANCH) && cond) || (x_op == OPC_JAL));
    // Same PC relative target for B and J immediates
    assign branch_target = x_pc + x_imm;

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core import rv_core_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  word_t                  instr,
    output logic                   retire_valid,
    input  logic                   retire_ready,
    output word_t                  retire_pc,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic                   retire_we,
    output word_t                  retire_data
);

    // Execute register
    logic                   x_valid;
    word_t                  x_pc;
    opcode_e                x_op;
    alu_op_e                x_alu_op;
    logic [2:0]             x_funct3;
    word_t                  x_rs1_val;
    word_t                  x_rs2_val;
    word_t                  x_imm;
    logic [`REG_ADDR_W-1:0] x_rd;
    logic                   x_rd_we;

    // Execute results and feedback
    word_t                  alu_result;
    logic                   branch_taken;
    word_t                  branch_target;
    logic                   x_advance;
    logic                   redirect_valid;
    word_t                  redirect_pc;

    rv_decode_stage u_decode (
        .clk            (clk),
        .arst_n         (arst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .x_advance      (x_advance),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .alu_result     (alu_result),
        .instr_ready    (instr_ready),
        .x_valid        (x_valid),
        .x_pc           (x_pc),
        .x_op           (x_op),
        .x_alu_op       (x_alu_op),
        .x_funct3       (x_funct3),
        .x_rs1_val      (x_rs1_val),
        .x_rs2_val      (x_rs2_val),
        .x_imm          (x_imm),
        .x_rd           (x_rd),
        .x_rd_we        (x_rd_we)
    );

    rv_alu u_alu (
        .x_op       (x_op),
        .x_alu_op   (x_alu_op),
        .x_pc       (x_pc),
        .x_rs1_val  (x_rs1_val),
        .x_rs2_val  (x_rs2_val),
        .x_imm      (x_imm),
        .alu_result (alu_result)
    );

    rv_branch_unit u_branch (
        .x_valid       (x_valid),
        .x_op          (x_op),
        .x_funct3      (x_funct3),
        .x_pc          (x_pc),
        .x_rs1_val     (x_rs1_val),
        .x_rs2_val     (x_rs2_val),
        .x_imm         (x_imm),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    rv_retire u_retire (
        .clk            (clk),
        .arst_n         (arst_n),
        .x_valid        (x_valid),
        .x_pc           (x_pc),
        .x_rd           (x_rd),
        .x_rd_we        (x_rd_we),
        .alu_result     (alu_result),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .retire_ready   (retire_ready),
        .x_advance      (x_advance),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_we      (retire_we),
        .retire_data    (retire_data)
    );

endmodule

/* hdl/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Core wide constants
//////////////////////////////////////////////////////////////////////

// Data and instruction width
`define XLEN 32

// Register index width for the 32 architectural registers
`define REG_ADDR_W 5

// Address of the first instruction after reset
`define RESET_PC 32'h4000_0000

`endif

/* hdl/rv_core_pkg.sv */
`include "rv_core_defines.svh"

package rv_core_pkg;

    // One machine word
    typedef logic [`XLEN-1:0] word_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

/* hdl/rv_decode_stage.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_decode_stage import rv_core_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_valid,
    input  word_t                  instr,
    input  logic                   x_advance,
    input  logic                   redirect_valid,
    input  word_t                  redirect_pc,
    input  word_t                  alu_result,
    output logic                   instr_ready,
    output logic                   x_valid,
    output word_t                  x_pc,
    output opcode_e                x_op,
    output alu_op_e                x_alu_op,
    output logic [2:0]             x_funct3,
    output word_t                  x_rs1_val,
    output word_t                  x_rs2_val,
    output word_t                  x_imm,
    output logic [`REG_ADDR_W-1:0] x_rd,
    output logic                   x_rd_we
);

    word_t                  pc;
    logic                   annul;
    logic                   accept;
    logic                   kill;
    logic                   issue;
    opcode_e                op;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    alu_op_e                alu_op;
    logic                   rd_we;
    word_t                  imm;
    word_t                  rs1_val;
    word_t                  rs2_val;
    logic                   wb_en;
    word_t                  rf [2**`REG_ADDR_W];

    // Shared funct3 mapping for OP and OP-IMM
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Execute slot free or emptying this cycle
    assign instr_ready = !x_valid || x_advance;
    assign accept      = instr_valid && instr_ready;
    // Kill covers a pending annul and a redirect in this very cycle
    assign kill        = annul || redirect_valid;
    assign issue       = accept && !kill;

    //////////////////////////////////////////////////////////////////////
    // Decode and immediates
    //////////////////////////////////////////////////////////////////////

    assign op     = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        alu_op = ALU_ADD;
        rd_we  = 1'b0;
        imm    = '0;
        case (op)
            OPC_OP: begin
                alu_op = arith_op(funct3, funct7[5]);
                rd_we  = 1'b1;
            end
            OPC_OP_IMM: begin
                // Only the shift right uses bit 30 as a selector
                alu_op = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
                rd_we  = 1'b1;
                imm    = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                rd_we  = 1'b1;
                imm    = {instr[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                rd_we = 1'b1;
                imm   = {instr[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                rd_we = 1'b1;
                imm   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // Unknown opcodes retire without a write
            default: rd_we = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register file with forwarding from execute
    //////////////////////////////////////////////////////////////////////

    assign wb_en = x_advance && x_rd_we && (x_rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_en) begin
            rf[x_rd] <= alu_result;
        end
    end

    // x0 is never written so rf[0] reads zero
    assign rs1_val = (wb_en && (x_rd == rs1)) ? alu_result : rf[rs1];
    assign rs2_val = (wb_en && (x_rd == rs2)) ? alu_result : rf[rs2];

    //////////////////////////////////////////////////////////////////////
    // PC, annul flag and execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `RESET_PC;
            annul   <= 1'b0;
            x_valid <= 1'b0;
        end else begin
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (issue) begin
                pc <= pc + 32'd4;
            end
            // The next accepted instruction consumes the annul
            if (accept) begin
                annul <= 1'b0;
            end else if (redirect_valid) begin
                annul <= 1'b1;
            end
            if (issue) begin
                x_valid <= 1'b1;
            end else if (x_advance) begin
                x_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            x_pc      <= pc;
            x_op      <= op;
            x_alu_op  <= alu_op;
            x_funct3  <= funct3;
            x_rs1_val <= rs1_val;
            x_rs2_val <= rs2_val;
            x_imm     <= imm;
            x_rd      <= rd;
            x_rd_we   <= rd_we;
        end
    end

endmodule

/* hdl/rv_retire.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_retire import rv_core_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   x_valid,
    input  word_t                  x_pc,
    input  logic [`REG_ADDR_W-1:0] x_rd,
    input  logic                   x_rd_we,
    input  word_t                  alu_result,
    input  logic                   branch_taken,
    input  word_t                  branch_target,
    input  logic                   retire_ready,
    output logic                   x_advance,
    output logic                   redirect_valid,
    output word_t                  redirect_pc,
    output logic                   retire_valid,
    output word_t                  retire_pc,
    output logic [`REG_ADDR_W-1:0] retire_rd,
    output logic                   retire_we,
    output word_t                  retire_data
);

    // Execute moves on when the retire slot is free or draining
    assign x_advance = x_valid && (!retire_valid || retire_ready);

    // Redirect only for a taken branch leaving execute
    assign redirect_valid = x_advance && branch_taken;
    assign redirect_pc    = branch_target;

    //////////////////////////////////////////////////////////////////////
    // Retire register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else if (x_advance) begin
            retire_valid <= 1'b1;
            // No architectural write for x0
            retire_we    <= x_rd_we && (x_rd != '0);
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (x_advance) begin
            retire_pc   <= x_pc;
            retire_rd   <= x_rd;
            retire_data <= alu_result;
        end
    end

endmodule

/* rv_core.f */
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_decode_stage.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_retire.sv
hdl/rv_core.sv
tb/rv_core_sva.sv
tb/tb_rv_core.sv

/* tb/rv_core_sva.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_sva import rv_core_pkg::*; (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   instr_ready,
    input logic                   x_valid,
    input logic                   retire_valid,
    input logic                   retire_ready,
    input word_t                  retire_pc,
    input logic [`REG_ADDR_W-1:0] retire_rd,
    input logic                   retire_we,
    input word_t                  retire_data
);

    // Retire port holds while stalled
    a_retire_hold: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
            && $stable(retire_rd) && $stable(retire_we) && $stable(retire_data))
        else $error("retire outputs changed while stalled");

    // Full execute slot behind a stalled retire blocks the input
    a_input_stall: assert property (@(posedge clk) disable iff (!arst_n)
        x_valid && retire_valid && !retire_ready |-> !instr_ready)
        else $error("instr_ready high while execute is full and stalled");

    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        retire_we |-> retire_rd != '0)
        else $error("retire_we high for x0");

endmodule

bind rv_core rv_core_sva u_sva (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_ready  (instr_ready),
    .x_valid      (x_valid),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we),
    .retire_data  (retire_data)
);

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module tb_rv_core import rv_core_pkg::*; ();

    localparam int NUM_INSTR  = 600;
    localparam int MAX_CYCLES = 20000;

    logic                   clk;
    logic                   arst_n;
    logic                   instr_valid;
    logic                   instr_ready;
    word_t                  instr;
    logic                   retire_valid;
    logic                   retire_ready;
    word_t                  retire_pc;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic                   retire_we;
    word_t                  retire_data;

    // Random source and the fields of the instruction on the input
    logic [31:0]            lfsr_state;
    opcode_e                g_op;
    logic [2:0]             g_f3;
    logic                   g_alt;
    logic [`REG_ADDR_W-1:0] g_rd;
    logic [`REG_ADDR_W-1:0] g_rs1;
    logic [`REG_ADDR_W-1:0] g_rs2;
    word_t                  g_imm;

    // Reference model state
    word_t                  regs [32];
    word_t                  m_pc;
    logic                   drop_next;
    word_t                  exp_pc [$];
    logic [`REG_ADDR_W-1:0] exp_rd [$];
    logic                   exp_we [$];
    word_t                  exp_data [$];

    int                     errors;
    int                     checks;
    int                     n_sent;
    int                     n_retired;
    int                     n_annul;
    int                     cycles;
    logic                   accepted;
    logic                   timed_out;

    rv_core uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Random numbers
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR with feedback polynomial x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ISA reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t isa_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                // Kept apart so the arithmetic shift stays signed
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic model_accept();
        word_t a;
        word_t b;
        word_t res;
        logic  taken;
        logic  we;
        // Slot after a taken branch or JAL is annulled
        if (drop_next) begin
            drop_next = 1'b0;
            n_annul++;
            return;
        end
        a     = regs[g_rs1];
        b     = regs[g_rs2];
        res   = '0;
        taken = 1'b0;
        we    = 1'b1;
        case (g_op)
            OPC_OP:     res = isa_alu(g_f3, g_alt, a, b);
            OPC_OP_IMM: res = isa_alu(g_f3, g_alt, a, g_imm);
            OPC_LUI:    res = g_imm;
            OPC_AUIPC:  res = m_pc + g_imm;
            OPC_BRANCH: begin
                we    = 1'b0;
                taken = branch_cond(g_f3, a, b);
            end
            default: begin
                res   = m_pc + 32'd4;
                taken = 1'b1;
            end
        endcase
        we = we && (g_rd != '0);
        if (we) begin
            regs[g_rd] = res;
        end
        exp_pc.push_back(m_pc);
        exp_rd.push_back(g_rd);
        exp_we.push_back(we);
        exp_data.push_back(res);
        m_pc      = taken ? m_pc + g_imm : m_pc + 32'd4;
        drop_next = taken;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////////////////////////

    task automatic gen_instr();
        logic [2:0]  pick;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [12:0] boff;
        logic [20:0] joff;
        pick  = 3'(rand_bits(3));
        // Only x0..x7 so that dependencies are frequent
        g_rd  = 5'(rand_bits(3));
        g_rs1 = 5'(rand_bits(3));
        g_rs2 = 5'(rand_bits(3));
        g_f3  = 3'(rand_bits(3));
        g_alt = 1'b0;
        g_imm = '0;
        case (pick)
            3'd0, 3'd1: begin
                g_op = OPC_OP;
                if (g_f3 == 3'b000 || g_f3 == 3'b101) begin
                    g_alt = 1'(rand_bits(1));
                end
                instr = {1'b0, g_alt, 5'b0, g_rs2, g_rs1, g_f3, g_rd, g_op};
            end
            3'd2, 3'd3: begin
                g_op  = OPC_OP_IMM;
                imm12 = 12'(rand_bits(12));
                // Shift immediates hold a shift amount and the arithmetic flag
                if (g_f3 == 3'b001) begin
                    imm12[11:5] = 7'b0;
                end
                if (g_f3 == 3'b101) begin
                    g_alt       = 1'(rand_bits(1));
                    imm12[11:5] = {1'b0, g_alt, 5'b0};
                end
                g_imm = {{20{imm12[11]}}, imm12};
                instr = {imm12, g_rs1, g_f3, g_rd, g_op};
            end
            3'd4, 3'd5: begin
                if (pick == 3'd4) begin
                    g_op = OPC_LUI;
                end else begin
                    g_op = OPC_AUIPC;
                end
                imm20 = 20'(rand_bits(20));
                g_imm = {imm20, 12'b0};
                instr = {imm20, g_rd, g_op};
            end
            3'd6: begin
                g_op = OPC_BRANCH;
                // Reserved funct3 folded onto BLTU and BGEU
                if (g_f3[2:1] == 2'b01) begin
                    g_f3[2] = 1'b1;
                end
                boff  = {11'(rand_bits(11)), 2'b00};
                g_imm = {{19{boff[12]}}, boff};
                instr = {boff[12], boff[10:5], g_rs2, g_rs1, g_f3, boff[4:1], boff[11], g_op};
            end
            default: begin
                g_op  = OPC_JAL;
                joff  = {19'(rand_bits(19)), 2'b00};
                g_imm = {{11{joff[20]}}, joff};
                instr = {joff[20], joff[10:1], joff[11], joff[19:12], g_rd, g_op};
            end
        endcase
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_retirement();
        word_t                  e_pc;
        logic [`REG_ADDR_W-1:0] e_rd;
        logic                   e_we;
        word_t                  e_data;
        if (exp_pc.size() == 0) begin
            errors++;
            $display("Unexpected retirement at pc %h with nothing left in the model", retire_pc);
            return;
        end
        e_pc   = exp_pc.pop_front();
        e_rd   = exp_rd.pop_front();
        e_we   = exp_we.pop_front();
        e_data = exp_data.pop_front();
        n_retired++;
        check_equal("retire_pc", retire_pc, e_pc);
        check_equal($sformatf("retire_we at pc %h", e_pc), retire_we, e_we);
        // rd and data only carry meaning for a register write
        if (e_we) begin
            check_equal($sformatf("retire_rd at pc %h", e_pc), retire_rd, e_rd);
            check_equal($sformatf("retire_data at pc %h", e_pc), retire_data, e_data);
        end
    endtask

    task automatic drive_inputs();
        if (!instr_valid || accepted) begin
            if (n_sent < NUM_INSTR && rand_bits(2) != 32'd0) begin
                gen_instr();
                instr_valid = 1'b1;
                n_sent++;
            end else begin
                instr_valid = 1'b0;
            end
        end
        retire_ready = (rand_bits(2) != 32'd0);
    endtask

    // Both handshakes complete at the next rising edge
    task automatic sample_handshakes();
        accepted = instr_valid && instr_ready;
        if (retire_valid && retire_ready) begin
            check_retirement();
        end
        if (accepted) begin
            model_accept();
        end
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        retire_ready = 1'b0;
        lfsr_state   = 32'd87;
        m_pc         = `RESET_PC;
        drop_next    = 1'b0;
        accepted     = 1'b0;
        timed_out    = 1'b0;
        errors       = 0;
        checks       = 0;
        n_sent       = 0;
        n_retired    = 0;
        n_annul      = 0;
        cycles       = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_equal("retire_valid after reset", retire_valid, 1'b0);
        check_equal("instr_ready after reset", instr_ready, 1'b1);

        // Drive after each rising edge, sample at the falling edge
        while ((n_sent < NUM_INSTR || (instr_valid && !accepted) || exp_pc.size() != 0)
               && !timed_out) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            sample_handshakes();
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("Timeout: the core stopped accepting or retiring after %0d cycles", cycles);
        end else begin
            @(posedge clk);
            #1;
            instr_valid  = 1'b0;
            retire_ready = 1'b1;
            // Nothing may retire once the model is empty
            repeat (8) begin
                @(negedge clk);
                if (retire_valid) begin
                    errors++;
                    $display("Extra retirement at pc %h beyond the model", retire_pc);
                end
            end
        end

        $display("checks=%0d errors=%0d sent=%0d retired=%0d annulled=%0d",
                 checks, errors, n_sent, n_retired, n_annul);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
